// File: design/idiv_pkg.sv
`default_nettype none

package idiv_pkg;

	// ====================
	// Datapath widths
	// ====================

	// One full operand or result word of the packed datapath
	typedef logic [63:0] value_t;

	// One bit per byte of value_t
	// Used for the copy-target mask and for the exception vector
	typedef logic [7:0] byte_mask_t;

	// Destination register tag that rides along with an operation
	typedef logic [5:0] tag_t;

	// ====================
	// Control encodings
	// ====================

	// Lane precision of the packed word
	// Code 2'd3 is not named and is decoded the same as PRC_64
	typedef enum logic [1:0] {
		PRC_16 = 2'd0,
		PRC_32 = 2'd1,
		PRC_64 = 2'd2
	} prc_t;

	// Which half of the division result a lane hands back
	typedef enum logic {
		OP_QUO = 1'b0,
		OP_REM = 1'b1
	} div_op_t;

	// Sequencer of one divider lane
	// ST_RUN covers the operand setup cycle and all shift-subtract steps
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_RUN  = 2'd1,
		ST_DONE = 2'd2
	} lane_state_t;

endpackage

`default_nettype wire

// File: design/idiv_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_cfg_regs (
	input  logic             clk,
	input  logic             rst,
	input  logic             cfg_we_i,
	input  idiv_pkg::prc_t   cfg_prc_i,
	input  logic             cfg_signed_i,
	output idiv_pkg::prc_t   prc_o,
	output logic             signed_o
);

	import idiv_pkg::*;

	prc_t prc_q;
	logic signed_q;

	// Both fields are written together by the one-cycle strobe
	// After reset the unit behaves as a plain unsigned 64-bit divider
	always_ff @(posedge clk) begin
		if (rst) begin
			prc_q <= PRC_64;
			signed_q <= 1'b0;
		end else if (cfg_we_i) begin
			prc_q <= cfg_prc_i;
			signed_q <= cfg_signed_i;
		end
	end

	// The divide unit only samples these at a load strobe
	// So a write in the middle of an operation shows up on the next one
	assign prc_o = prc_q;
	assign signed_o = signed_q;

	// An unknown precision would poison every later lane select
	a_prc_known: assert property (
		@(posedge clk) disable iff (rst)
		cfg_we_i |-> !$isunknown(cfg_prc_i)
	);

endmodule

`default_nettype wire

// File: design/idiv_lane.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_lane #(
	parameter int WID = 16
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           start_i,
	input  logic           signed_i,
	input  logic [WID-1:0] a_i,
	input  logic [WID-1:0] b_i,
	output logic [WID-1:0] quo_o,
	output logic [WID-1:0] rem_o,
	output logic           dbz_o,
	output logic           lane_done_o
);

	import idiv_pkg::*;

	// Counter runs 0 for the setup cycle, then 1 to WID for the steps
	localparam int CW = $clog2(WID + 1);

	lane_state_t state;
	logic [CW-1:0] cnt;

	// Raw operands as loaded, the dividend is also the divide-by-zero remainder
	logic [WID-1:0] a_r;
	logic [WID-1:0] b_r;
	logic sgn_r;

	// Working registers of the restoring divider
	logic [WID-1:0] q;
	logic [WID-1:0] d;
	logic [WID-1:0] rem;
	logic neg_q;
	logic neg_r;
	logic dbz_q;

	logic [WID:0] r_shift;
	logic [WID:0] diff;

	// ====================
	// Sequencer
	// ====================

	// A start in any state restarts the lane, which abandons a running divide
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			cnt <= '0;
			dbz_q <= 1'b0;
		end else if (start_i) begin
			state <= ST_RUN;
			cnt <= '0;
		end else if (state == ST_RUN) begin
			cnt <= cnt + 1'b1;
			// Zero divisor is noted in the setup cycle and the steps still run
			if (cnt == '0)
				dbz_q <= (b_r == '0);
			if (cnt == CW'(WID))
				state <= ST_DONE;
		end
	end

	// ====================
	// Datapath
	// ====================

	// Bring down the next dividend bit and try to subtract the divisor
	always_comb begin
		r_shift = {rem, q[WID-1]};
		diff = r_shift - {1'b0, d};
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			a_r <= a_i;
			b_r <= b_i;
			sgn_r <= signed_i;
		end else if (state == ST_RUN) begin
			if (cnt == '0) begin
				// Setup takes magnitudes and records the result signs
				q <= (sgn_r && a_r[WID-1]) ? -a_r : a_r;
				d <= (sgn_r && b_r[WID-1]) ? -b_r : b_r;
				rem <= '0;
				neg_q <= sgn_r && (a_r[WID-1] ^ b_r[WID-1]);
				neg_r <= sgn_r && a_r[WID-1];
			end else if (diff[WID]) begin
				// Trial went negative so the partial remainder is restored
				rem <= r_shift[WID-1:0];
				q <= {q[WID-2:0], 1'b0};
			end else begin
				rem <= diff[WID-1:0];
				q <= {q[WID-2:0], 1'b1};
			end
		end
	end

	// Quotient truncates toward zero and the remainder follows the dividend sign
	assign quo_o = dbz_q ? '1 : (neg_q ? -q : q);
	assign rem_o = dbz_q ? a_r : (neg_r ? -rem : rem);
	assign dbz_o = dbz_q;

	// Level is high while idle or finished and low through setup and steps
	assign lane_done_o = (state != ST_RUN);

	a_done_falls_on_start: assert property (
		@(posedge clk) disable iff (rst)
		$fell(lane_done_o) |-> $past(start_i)
	);

	a_step_bound: assert property (
		@(posedge clk) disable iff (rst)
		(state == ST_RUN) |-> (cnt <= CW'(WID))
	);

endmodule

`default_nettype wire

// File: design/idiv_meta.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_meta #(
	parameter bit SUPPORT_PREC = 1'b1
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ld_i,
	input  idiv_pkg::div_op_t    op_i,
	input  idiv_pkg::prc_t       prc_i,
	input  logic                 signed_i,
	input  idiv_pkg::value_t     a_i,
	input  idiv_pkg::value_t     b_i,
	input  idiv_pkg::value_t     t_i,
	input  idiv_pkg::byte_mask_t cptgt_i,
	input  logic                 zero_i,
	input  idiv_pkg::tag_t       tag_i,
	output idiv_pkg::value_t     res_o,
	output idiv_pkg::byte_mask_t exc_o,
	output logic                 dbz_o,
	output logic                 done_o,
	output logic                 valid_o,
	output idiv_pkg::tag_t       tag_o
);

	import idiv_pkg::*;

	// Operation context held from the load edge until the result strobe
	div_op_t op_q;
	prc_t prc_q;
	value_t t_q;
	byte_mask_t cptgt_q;
	logic zero_q;
	tag_t tag_q;
	logic busy_q;

	value_t quo16, rem16, quo32, rem32, quo64, rem64;
	logic [3:0] dbz16, done16;
	logic [1:0] dbz32, done32;
	logic dbz64, done64;

	prc_t prc_sel;
	value_t sel_val, res_m, res_hold;
	byte_mask_t sel_exc, exc_m;
	logic sel_done;

	// ====================
	// Lane sets
	// ====================

	// Every lane starts on every load, only the latched precision is used later
	generate
		if (SUPPORT_PREC) begin : g_prec
			for (genvar g = 0; g < 4; g++) begin : g_l16
				idiv_lane #(.WID(16)) u_lane (
					.clk(clk),
					.rst(rst),
					.start_i(ld_i),
					.signed_i(signed_i),
					.a_i(a_i[g*16 +: 16]),
					.b_i(b_i[g*16 +: 16]),
					.quo_o(quo16[g*16 +: 16]),
					.rem_o(rem16[g*16 +: 16]),
					.dbz_o(dbz16[g]),
					.lane_done_o(done16[g])
				);
			end
			for (genvar g = 0; g < 2; g++) begin : g_l32
				idiv_lane #(.WID(32)) u_lane (
					.clk(clk),
					.rst(rst),
					.start_i(ld_i),
					.signed_i(signed_i),
					.a_i(a_i[g*32 +: 32]),
					.b_i(b_i[g*32 +: 32]),
					.quo_o(quo32[g*32 +: 32]),
					.rem_o(rem32[g*32 +: 32]),
					.dbz_o(dbz32[g]),
					.lane_done_o(done32[g])
				);
			end
		end else begin : g_noprec
			// Narrow sets are absent and read as idle
			assign quo16 = '0;
			assign rem16 = '0;
			assign dbz16 = '0;
			assign done16 = '1;
			assign quo32 = '0;
			assign rem32 = '0;
			assign dbz32 = '0;
			assign done32 = '1;
		end
	endgenerate

	idiv_lane #(.WID(64)) u_lane64 (
		.clk(clk),
		.rst(rst),
		.start_i(ld_i),
		.signed_i(signed_i),
		.a_i(a_i),
		.b_i(b_i),
		.quo_o(quo64),
		.rem_o(rem64),
		.dbz_o(dbz64),
		.lane_done_o(done64)
	);

	// ====================
	// Context and result
	// ====================

	always_ff @(posedge clk) begin
		if (ld_i) begin
			op_q <= op_i;
			prc_q <= prc_i;
			t_q <= t_i;
			cptgt_q <= cptgt_i;
			zero_q <= zero_i;
			tag_q <= tag_i;
		end
	end

	// Without precision support the setting is ignored and one 64-bit lane runs
	assign prc_sel = SUPPORT_PREC ? prc_q : PRC_64;

	// A lane's divide-by-zero flag covers all bytes of that lane
	always_comb begin
		case (prc_sel)
			PRC_16: begin
				sel_val = (op_q == OP_QUO) ? quo16 : rem16;
				sel_done = &done16;
				for (int k = 0; k < 8; k++)
					sel_exc[k] = dbz16[k/2];
			end
			PRC_32: begin
				sel_val = (op_q == OP_QUO) ? quo32 : rem32;
				sel_done = &done32;
				for (int k = 0; k < 8; k++)
					sel_exc[k] = dbz32[k/4];
			end
			default: begin
				sel_val = (op_q == OP_QUO) ? quo64 : rem64;
				sel_done = done64;
				sel_exc = {8{dbz64}};
			end
		endcase
	end

	// Masked bytes take the old target or zero and never raise an exception
	always_comb begin
		for (int k = 0; k < 8; k++)
			res_m[k*8 +: 8] = cptgt_q[k] ? (zero_q ? 8'h00 : t_q[k*8 +: 8]) : sel_val[k*8 +: 8];
		exc_m = sel_exc & ~cptgt_q;
	end

	// A load in the finishing cycle wins and the old result is dropped
	assign valid_o = busy_q && sel_done && !ld_i;

	always_ff @(posedge clk) begin
		if (rst)
			busy_q <= 1'b0;
		else if (ld_i)
			busy_q <= 1'b1;
		else if (valid_o)
			busy_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (valid_o)
			res_hold <= res_m;
	end

	assign res_o = valid_o ? res_m : res_hold;
	assign exc_o = valid_o ? exc_m : '0;
	assign tag_o = valid_o ? tag_q : '0;
	assign dbz_o = |exc_o;
	assign done_o = !ld_i && (valid_o || !busy_q);

	// The lanes must drop their done level right after a load
	a_no_valid_at_load: assert property (
		@(posedge clk) disable iff (rst)
		ld_i |-> !valid_o ##1 !valid_o
	);

endmodule

`default_nettype wire

// File: design/idiv_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_unit_top #(
	parameter bit SUPPORT_PREC = 1'b1
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cfg_we_i,
	input  idiv_pkg::prc_t       cfg_prc_i,
	input  logic                 cfg_signed_i,
	input  logic                 ld_i,
	input  idiv_pkg::div_op_t    op_i,
	input  idiv_pkg::value_t     a_i,
	input  idiv_pkg::value_t     b_i,
	input  idiv_pkg::value_t     t_i,
	input  idiv_pkg::byte_mask_t cptgt_i,
	input  logic                 zero_i,
	input  idiv_pkg::tag_t       tag_i,
	output idiv_pkg::value_t     res_o,
	output idiv_pkg::byte_mask_t exc_o,
	output logic                 dbz_o,
	output logic                 done_o,
	output logic                 valid_o,
	output idiv_pkg::tag_t       tag_o
);

	import idiv_pkg::*;

	// Registered configuration feeding the divide unit
	prc_t cfg_prc;
	logic cfg_signed;

	idiv_cfg_regs u_cfg (
		.clk(clk),
		.rst(rst),
		.cfg_we_i(cfg_we_i),
		.cfg_prc_i(cfg_prc_i),
		.cfg_signed_i(cfg_signed_i),
		.prc_o(cfg_prc),
		.signed_o(cfg_signed)
	);

	idiv_meta #(.SUPPORT_PREC(SUPPORT_PREC)) u_meta (
		.clk(clk),
		.rst(rst),
		.ld_i(ld_i),
		.op_i(op_i),
		.prc_i(cfg_prc),
		.signed_i(cfg_signed),
		.a_i(a_i),
		.b_i(b_i),
		.t_i(t_i),
		.cptgt_i(cptgt_i),
		.zero_i(zero_i),
		.tag_i(tag_i),
		.res_o(res_o),
		.exc_o(exc_o),
		.dbz_o(dbz_o),
		.done_o(done_o),
		.valid_o(valid_o),
		.tag_o(tag_o)
	);

endmodule

`default_nettype wire

// File: testbench/idiv_tb_pkg.svh
`ifndef IDIV_TB_PKG_SVH
`define IDIV_TB_PKG_SVH

// ====================
// Reference model
// ====================

// Lane width selected by a precision code, the unnamed code behaves as 64 bits
function automatic int lane_width(input prc_t prc);
	case (prc)
		PRC_16: return 16;
		PRC_32: return 32;
		default: return 64;
	endcase
endfunction

// All ones in the low w bits of a word
function automatic value_t lane_mask(input int w);
	return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
endfunction

// Expected packed result and exception bytes of one operation
// Each lane divides magnitudes, then the quotient takes the XOR of the signs
// and the remainder the sign of the dividend
function automatic void ref_result(
	input  prc_t       prc,
	input  logic       sgn,
	input  div_op_t    op,
	input  value_t     a,
	input  value_t     b,
	input  value_t     t,
	input  byte_mask_t cptgt,
	input  logic       zero,
	output value_t     res,
	output byte_mask_t exc
);
	int w;
	value_t msk, la, lb, ma, mb, lq, lr;
	logic neg_a, neg_b;
	w = lane_width(prc);
	msk = lane_mask(w);
	res = '0;
	exc = '0;
	for (int l = 0; l < 64 / w; l++) begin
		la = (a >> (l * w)) & msk;
		lb = (b >> (l * w)) & msk;
		neg_a = sgn && la[w-1];
		neg_b = sgn && lb[w-1];
		ma = neg_a ? ((~la + 64'd1) & msk) : la;
		mb = neg_b ? ((~lb + 64'd1) & msk) : lb;
		if (lb == '0) begin
			// Zero divisor flags every byte of the lane
			lq = msk;
			lr = la;
			for (int k = l * w / 8; k < (l + 1) * w / 8; k++)
				exc[k] = 1'b1;
		end else begin
			lq = ma / mb;
			lr = ma % mb;
			if (neg_a != neg_b)
				lq = (~lq + 64'd1) & msk;
			if (neg_a)
				lr = (~lr + 64'd1) & msk;
		end
		res = res | (((op == OP_QUO) ? lq : lr) << (l * w));
	end
	// Copy-target bytes replace the lane result and drop their exception
	for (int k = 0; k < 8; k++) begin
		if (cptgt[k]) begin
			res[k*8 +: 8] = zero ? 8'h00 : t[k*8 +: 8];
			exc[k] = 1'b0;
		end
	end
endfunction

// ====================
// Compare tasks
// ====================

task automatic check_value(input string name, input value_t exp_v, input value_t act_v);
	if (act_v !== exp_v)
		report_failure($sformatf("FAIL %s res_o: expected %h, actual %h", name, exp_v, act_v));
endtask

task automatic check_mask(input string name, input byte_mask_t exp_v, input byte_mask_t act_v);
	if (act_v !== exp_v)
		report_failure($sformatf("FAIL %s exc_o: expected %b, actual %b", name, exp_v, act_v));
endtask

task automatic check_tag(input string name, input tag_t exp_v, input tag_t act_v);
	if (act_v !== exp_v)
		report_failure($sformatf("FAIL %s tag_o: expected %h, actual %h", name, exp_v, act_v));
endtask

task automatic check_flag(input string name, input logic exp_v, input logic act_v);
	if (act_v !== exp_v)
		report_failure($sformatf("FAIL %s dbz_o: expected %b, actual %b", name, exp_v, act_v));
endtask

`endif

// File: testbench/idiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_tb;

	import idiv_pkg::*;

	localparam int N_OPS = 300;
	localparam int N_RANDOM = 291;
	localparam int TIMEOUT_CYCLES = N_OPS * 80 + 100;

	logic clk = 1'b0;
	logic rst;
	logic cfg_we_i;
	prc_t cfg_prc_i;
	logic cfg_signed_i;
	logic ld_i;
	div_op_t op_i;
	value_t a_i, b_i, t_i;
	byte_mask_t cptgt_i;
	logic zero_i;
	tag_t tag_i;
	value_t res_o;
	byte_mask_t exc_o;
	logic dbz_o, done_o, valid_o;
	tag_t tag_o;

	// Expectation of the operation in flight is set at load and cleared by the checker
	logic pending;
	string exp_name;
	value_t exp_res;
	byte_mask_t exp_exc;
	tag_t exp_tag;

	// Configuration as the DUT holds it after the last write
	prc_t cur_prc;
	logic cur_sgn;
	tag_t next_tag;
	int n_loaded, n_abandoned, n_checked;
	int cycles = 0;

	idiv_unit_top #(.SUPPORT_PREC(1'b1)) DUT (
		.clk(clk),
		.rst(rst),
		.cfg_we_i(cfg_we_i),
		.cfg_prc_i(cfg_prc_i),
		.cfg_signed_i(cfg_signed_i),
		.ld_i(ld_i),
		.op_i(op_i),
		.a_i(a_i),
		.b_i(b_i),
		.t_i(t_i),
		.cptgt_i(cptgt_i),
		.zero_i(zero_i),
		.tag_i(tag_i),
		.res_o(res_o),
		.exc_o(exc_o),
		.dbz_o(dbz_o),
		.done_o(done_o),
		.valid_o(valid_o),
		.tag_o(tag_o)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	`include "idiv_tb_pkg.svh"

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
			report_failure("Timeout: the run went past its cycle limit");
	end

	// ====================
	// Stimulus helpers
	// ====================

	// Per lane zero_sel clears the divisor and small_sel shrinks it to 5 bits of either sign
	function automatic value_t shape_divisor(input prc_t prc, input value_t b,
		input logic [7:0] zero_sel, input logic [7:0] small_sel);
		int w;
		value_t msk, lb;
		w = lane_width(prc);
		msk = lane_mask(w);
		for (int l = 0; l < 64 / w; l++) begin
			lb = (b >> (l * w)) & msk;
			if (zero_sel[l])
				lb = '0;
			else if (small_sel[l])
				lb = lb[w-1] ? (((~(lb & 64'h1F)) + 64'd1) & msk) : (lb & 64'h1F);
			b = (b & ~(msk << (l * w))) | (lb << (l * w));
		end
		return b;
	endfunction

	task automatic write_cfg(input prc_t prc, input logic sgn);
		@(posedge clk);
		#1;
		cfg_we_i = 1'b1;
		cfg_prc_i = prc;
		cfg_signed_i = sgn;
		@(posedge clk);
		#1;
		cfg_we_i = 1'b0;
		cur_prc = prc;
		cur_sgn = sgn;
	endtask

	// Drives a one-cycle load and records what the checker should see
	task automatic start_op(input string name, input div_op_t op, input value_t a,
		input value_t b, input value_t t, input byte_mask_t cptgt, input logic zero);
		value_t r;
		byte_mask_t e;
		ref_result(cur_prc, cur_sgn, op, a, b, t, cptgt, zero, r, e);
		@(posedge clk);
		#1;
		if (pending)
			n_abandoned++;
		ld_i = 1'b1;
		op_i = op;
		a_i = a;
		b_i = b;
		t_i = t;
		cptgt_i = cptgt;
		zero_i = zero;
		tag_i = next_tag;
		exp_name = name;
		exp_res = r;
		exp_exc = e;
		exp_tag = next_tag;
		pending = 1'b1;
		next_tag = next_tag + 1'b1;
		n_loaded++;
		@(posedge clk);
		#1;
		ld_i = 1'b0;
	endtask

	task automatic wait_result();
		while (pending)
			@(posedge clk);
	endtask

	task automatic run_op(input string name, input div_op_t op, input value_t a,
		input value_t b, input value_t t, input byte_mask_t cptgt, input logic zero);
		start_op(name, op, a, b, t, cptgt, zero);
		wait_result();
	endtask

	// ====================
	// Checker
	// ====================

	// Outputs are sampled mid-cycle well after the inputs settle
	always @(negedge clk) begin
		if (!rst) begin
			if (valid_o) begin
				if (!pending)
					report_failure("valid_o pulsed while no operation was pending");
				check_value(exp_name, exp_res, res_o);
				check_mask(exp_name, exp_exc, exc_o);
				check_tag(exp_name, exp_tag, tag_o);
				check_flag(exp_name, |exp_exc, dbz_o);
				pending = 1'b0;
				n_checked++;
			end else begin
				if (pending && done_o)
					report_failure("done_o is high while an operation is still running");
				if (!pending && !done_o)
					report_failure("done_o is low while the unit is idle");
				check_tag("idle outputs", '0, tag_o);
				check_mask("idle outputs", '0, exc_o);
			end
		end
	end

	// ====================
	// Test sequence
	// ====================

	initial begin
		prc_t prc;
		logic sgn;
		div_op_t op;
		value_t a, b, t;
		byte_mask_t m;
		logic [7:0] zsel;
		void'($urandom(64656));
		rst = 1'b1;
		cfg_we_i = 1'b0;
		cfg_prc_i = PRC_64;
		cfg_signed_i = 1'b0;
		ld_i = 1'b0;
		op_i = OP_QUO;
		a_i = '0;
		b_i = '0;
		t_i = '0;
		cptgt_i = '0;
		zero_i = 1'b0;
		tag_i = '0;
		pending = 1'b0;
		cur_prc = PRC_64;
		cur_sgn = 1'b0;
		next_tag = '0;
		n_loaded = 0;
		n_abandoned = 0;
		n_checked = 0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		if (!done_o || valid_o || dbz_o)
			report_failure("done_o, valid_o or dbz_o has the wrong level after reset");

		// Most negative value over minus one wraps back to itself
		write_cfg(PRC_16, 1'b1);
		run_op("min_by_minus_one_16", OP_QUO, {4{16'h8000}}, '1, '0, '0, 1'b0);
		write_cfg(PRC_32, 1'b1);
		run_op("min_by_minus_one_32", OP_QUO, {2{32'h8000_0000}}, '1, '0, '0, 1'b0);
		write_cfg(PRC_64, 1'b1);
		run_op("min_by_minus_one_64", OP_QUO, 64'h8000_0000_0000_0000, '1, '0, '0, 1'b0);

		// Zero divisor in one lane and then hidden under a full mask
		write_cfg(PRC_16, 1'b0);
		a = {$urandom, $urandom};
		t = {$urandom, $urandom};
		run_op("dbz_lane2", OP_QUO, a, 64'h0005_0000_0007_0003, '0, '0, 1'b0);
		run_op("dbz_masked", OP_REM, a, '0, t, 8'hFF, 1'b0);

		// A config write mid-run only affects the next load
		write_cfg(PRC_64, 1'b0);
		b = 64'hFFFF_0123_8000_0007;
		start_op("cfg_write_mid_run", OP_QUO, a, b, '0, '0, 1'b0);
		repeat (10) @(posedge clk);
		write_cfg(PRC_16, 1'b1);
		wait_result();
		run_op("cfg_after_write", OP_QUO, a, b, '0, '0, 1'b0);

		// Restart before the 16-bit lanes finish so that only the second load may answer
		start_op("abandoned", OP_REM, a, b, '0, '0, 1'b0);
		repeat (8) @(posedge clk);
		start_op("restart", OP_QUO, {$urandom, $urandom}, b, '0, '0, 1'b0);
		wait_result();
		repeat (80) @(posedge clk);

		for (int i = 0; i < N_RANDOM; i++) begin
			prc = prc_t'($urandom % 4);
			sgn = 1'($urandom % 2);
			op = div_op_t'($urandom % 2);
			a = {$urandom, $urandom};
			t = {$urandom, $urandom};
			zsel = ($urandom % 4 == 0) ? 8'($urandom) : 8'h00;
			b = shape_divisor(prc, {$urandom, $urandom}, zsel, 8'($urandom));
			m = ($urandom % 3 == 0) ? 8'($urandom) : 8'h00;
			write_cfg(prc, sgn);
			run_op($sformatf("random_%0d", i), op, a, b, t, m, 1'($urandom % 2));
		end

		repeat (5) @(posedge clk);
		if (n_checked == n_loaded - n_abandoned) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			report_failure("Some operations never produced a result strobe");
		end
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+testbench
design/idiv_pkg.sv
design/idiv_cfg_regs.sv
design/idiv_lane.sv
design/idiv_meta.sv
design/idiv_unit_top.sv
testbench/idiv_tb.sv
